//--- dram_tge_top.f
+incdir+design
design/tge_pkg.sv
design/dram_rd_fifo.sv
design/dram_unpack.sv
design/tge_credit_tx.sv
design/tge_ctrl_regs.sv
design/dram_tge_top.sv
dv/dram_tge_properties.sv
dv/dram_tge_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The simulator exits non-zero when the run ends in $fatal or a failed assertion.
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -Wno-fatal \
    --top-module dram_tge_tb -f dram_tge_top.f
./obj_dir/Vdram_tge_tb

//--- dv/dram_tge_tb.sv
`include "tge_defs.svh"

module dram_tge_tb;
    import tge_pkg::*;

    localparam int TOTAL_WORDS = 80;
    localparam int MAX_CYCLES  = 4000;

    logic        clk;
    logic        rst;
    dram_word_u  dram_word;
    logic        dram_push;
    logic        dram_credit;
    tge_beat_t   tge_beat;
    logic        tge_valid;
    logic        tge_credit;
    logic        reg_we;
    reg_addr_e   reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;

    logic [31:0]        lfsr = 32'hfd08;
    logic [`DRAM_W-1:0] first_word;
    tge_beat_t          expected [$];
    tge_beat_t          head;
    logic               quiet = 1'b0;
    int                 words_pushed = 0;
    int                 credits_back = 0;
    int                 credits_granted = 0;
    int                 beats_seen = 0;
    int                 cycles = 0;

    dram_tge_top dram_tge_top_inst (.*);

    always #2 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    // Split one pair into nine beats. Lane 4 straddles the two words.
    task automatic queue_pair(input logic [`DRAM_W-1:0] lo, input logic [`DRAM_W-1:0] hi);
        tge_beat_t b;
        for (int i = 0; i < `BEATS_PER_PAIR; i++) begin
            b.lane = 4'(i);
            if (i < 4) begin
                b.data = lo[`TGE_W*i +: `TGE_W];
            end else if (i == 4) begin
                b.data = {hi[31:0], lo[`DRAM_W-1 -: 32]};
            end else begin
                b.data = hi[32 + `TGE_W*(i-5) +: `TGE_W];
            end
            expected.push_back(b);
        end
    endtask

    task automatic drive_cycle(input logic grant_all);
        logic               want_push;
        logic               grant;
        logic               bit_val;
        logic [`DRAM_W-1:0] word;
        @(negedge clk);
        draw_bit(want_push);
        draw_bit(grant);
        tge_credit = grant || grant_all;
        dram_push = 1'b0;
        if (want_push && words_pushed < TOTAL_WORDS
                && words_pushed < credits_back + `DRAM_FIFO_DEPTH) begin
            for (int i = 0; i < `DRAM_W; i++) begin
                draw_bit(bit_val);
                word[i] = bit_val;
            end
            dram_word.raw = word;
            dram_push = 1'b1;
            if (words_pushed % 2 == 0) begin
                first_word = word;
            end else begin
                queue_pair(first_word, word);
            end
            words_pushed++;
        end
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
        @(negedge clk);
        dram_push = 1'b0;
        tge_credit = 1'b0;
        reg_we = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    task automatic check_reg(input reg_addr_e addr, input logic [31:0] exp_val,
                             input string name);
        @(negedge clk);
        dram_push = 1'b0;
        tge_credit = 1'b0;
        reg_addr = addr;
        #1;
        assert (reg_rdata == exp_val) else begin
            fail_run($sformatf("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
                $time, name, exp_val, reg_rdata));
        end
    endtask

    // Credit bookkeeping and the scoreboard run on the rising edge.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            fail_run("Timeout: the run did not finish within the cycle limit.");
        end
        if (!rst) begin
            if (tge_credit) begin
                credits_granted++;
            end
            if (dram_credit) begin
                credits_back++;
            end
            if (tge_valid) begin
                beats_seen++;
                if (expected.size() == 0) begin
                    fail_run("A beat left on tge_valid while none was expected.");
                end else begin
                    head = expected.pop_front();
                    assert (tge_beat == head) else begin
                        fail_run($sformatf("MISMATCH time=%0t signal=tge_beat expected=%h actual=%h",
                            $time, head, tge_beat));
                    end
                end
            end
            assert (beats_seen <= credits_granted) else begin
                fail_run("More beats left than TGE credits were granted.");
            end
            if (quiet) begin
                assert (!tge_valid) else begin
                    fail_run("A beat left while the unpacker was disabled and drained.");
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        dram_word = '0;
        dram_push = 1'b0;
        tge_credit = 1'b0;
        reg_we = 1'b0;
        reg_addr = REG_CTRL;
        reg_wdata = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        assert (!tge_valid && !dram_credit) else begin
            fail_run("tge_valid or dram_credit high right after reset.");
        end
        check_reg(REG_CTRL, 32'd0, "reg_rdata(REG_CTRL)");
        check_reg(REG_PAIRS, 32'd0, "reg_rdata(REG_PAIRS)");
        check_reg(REG_BEATS, 32'd0, "reg_rdata(REG_BEATS)");

        write_reg(REG_CTRL, 32'd1);
        repeat (300) drive_cycle(1'b0);

        // With enable cleared the pair in flight drains and the FIFO fills up.
        write_reg(REG_CTRL, 32'd0);
        repeat (30) drive_cycle(1'b1);
        quiet = 1'b1;
        repeat (40) drive_cycle(1'b1);
        quiet = 1'b0;
        assert (beats_seen % `BEATS_PER_PAIR == 0) else begin
            fail_run("Clearing enable stopped the unpacker inside a pair.");
        end

        write_reg(REG_CTRL, 32'd1);
        while (words_pushed < TOTAL_WORDS || expected.size() != 0) begin
            drive_cycle(1'b0);
        end
        assert (credits_back == words_pushed) else begin
            fail_run($sformatf("MISMATCH time=%0t signal=dram_credit expected=%0d actual=%0d",
                $time, words_pushed, credits_back));
        end
        check_reg(REG_PAIRS, 32'(TOTAL_WORDS / 2), "reg_rdata(REG_PAIRS)");
        check_reg(REG_BEATS, 32'(TOTAL_WORDS / 2 * `BEATS_PER_PAIR), "reg_rdata(REG_BEATS)");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- dv/dram_tge_properties.sv
`include "tge_defs.svh"

module dram_tge_properties (
    input logic               clk,
    input logic               rst,
    input logic               dram_push,
    input logic               dram_credit,
    input logic               fifo_pop,
    input logic [2:0]         fifo_count,
    input logic               enable,
    input logic [3:0]         ext_cnt,
    input tge_pkg::tge_beat_t tge_beat,
    input logic               tge_valid
);

    // Both handshake outputs come out of reset low.
    reset_idle: assert property (@(posedge clk) rst |=> (!tge_valid && !dram_credit))
        else $error("tge_valid or dram_credit high after a reset cycle");

    // The DRAM source holds no credit while the FIFO is full.
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        dram_push |-> (fifo_count != 3'(`DRAM_FIFO_DEPTH)))
        else $error("DRAM word pushed into a full FIFO");

    // Each pop by the unpacker hands one credit back to the DRAM source a cycle later.
    credit_per_pop: assert property (@(posedge clk) disable iff (rst)
        dram_credit == $past(fifo_pop))
        else $error("dram_credit does not follow the FIFO pops one for one");

    // A beat goes out only on a held external credit.
    valid_needs_credit: assert property (@(posedge clk) disable iff (rst)
        tge_valid |-> ($past(ext_cnt) != 4'd0))
        else $error("tge_valid raised while the external credit count was zero");

    // A pop that does not follow a pop is the first word of a new pair.
    start_needs_enable: assert property (@(posedge clk) disable iff (rst)
        (fifo_pop && !$past(fifo_pop)) |-> enable)
        else $error("new pair popped from the FIFO while the unpacker was disabled");

    lane_in_range: assert property (@(posedge clk) disable iff (rst)
        tge_valid |-> (tge_beat.lane < 4'(`BEATS_PER_PAIR)))
        else $error("beat lane index out of range");

endmodule

bind dram_tge_top dram_tge_properties dram_tge_properties_inst (
    .clk         (clk),
    .rst         (rst),
    .dram_push   (dram_push),
    .dram_credit (dram_credit),
    .fifo_pop    (fifo_pop),
    .fifo_count  (fifo_count),
    .enable      (enable),
    .ext_cnt     (tge_credit_tx_inst.ext_cnt),
    .tge_beat    (tge_beat),
    .tge_valid   (tge_valid)
);

//--- design/dram_tge_top.sv
module dram_tge_top (
    input  logic                clk,
    input  logic                rst,
    input  tge_pkg::dram_word_u dram_word,
    input  logic                dram_push,
    output logic                dram_credit,
    output tge_pkg::tge_beat_t  tge_beat,
    output logic                tge_valid,
    input  logic                tge_credit,
    input  logic                reg_we,
    input  tge_pkg::reg_addr_e  reg_addr,
    input  logic [31:0]         reg_wdata,
    output logic [31:0]         reg_rdata
);
    import tge_pkg::*;

    dram_word_u fifo_dout;
    logic [2:0] fifo_count;
    logic       fifo_pop;
    tge_beat_t  beat;
    logic       beat_push;
    logic       beat_credit;
    logic       pair_done;
    logic       enable;

    dram_rd_fifo dram_rd_fifo_inst (
        .clk    (clk),
        .rst    (rst),
        .push   (dram_push),
        .din    (dram_word),
        .pop    (fifo_pop),
        .dout   (fifo_dout),
        .count  (fifo_count),
        .credit (dram_credit)
    );

    dram_unpack dram_unpack_inst (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .fifo_count  (fifo_count),
        .fifo_dout   (fifo_dout),
        .fifo_pop    (fifo_pop),
        .beat_push   (beat_push),
        .beat        (beat),
        .beat_credit (beat_credit),
        .pair_done   (pair_done)
    );

    tge_credit_tx tge_credit_tx_inst (
        .clk         (clk),
        .rst         (rst),
        .beat_push   (beat_push),
        .beat        (beat),
        .beat_credit (beat_credit),
        .tge_credit  (tge_credit),
        .tge_beat    (tge_beat),
        .tge_valid   (tge_valid)
    );

    // Beat counting uses the outgoing valid, so it matches what the sink saw.
    tge_ctrl_regs tge_ctrl_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .pair_done (pair_done),
        .tge_valid (tge_valid),
        .enable    (enable)
    );

endmodule

//--- design/tge_ctrl_regs.sv
module tge_ctrl_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               reg_we,
    input  tge_pkg::reg_addr_e reg_addr,
    input  logic [31:0]        reg_wdata,
    output logic [31:0]        reg_rdata,
    input  logic               pair_done,
    input  logic               tge_valid,
    output logic               enable
);
    import tge_pkg::*;

    logic [31:0] pairs_cnt;
    logic [31:0] beats_cnt;
    logic        wr_ctrl;
    logic        wr_pairs;
    logic        wr_beats;

    assign wr_ctrl  = reg_we && (reg_addr == REG_CTRL);
    assign wr_pairs = reg_we && (reg_addr == REG_PAIRS);
    assign wr_beats = reg_we && (reg_addr == REG_BEATS);

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
        end else if (wr_ctrl) begin
            enable <= reg_wdata[0];
        end
    end

    // Counters clear on any write to their address, whatever the data.
    always_ff @(posedge clk) begin
        if (rst) begin
            pairs_cnt <= '0;
        end else if (wr_pairs) begin
            pairs_cnt <= '0;
        end else if (pair_done) begin
            pairs_cnt <= pairs_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_cnt <= '0;
        end else if (wr_beats) begin
            beats_cnt <= '0;
        end else if (tge_valid) begin
            beats_cnt <= beats_cnt + 32'd1;
        end
    end

    // Read mux; unmapped addresses return zero.
    always_comb begin
        case (reg_addr)
            REG_CTRL:  reg_rdata = {31'd0, enable};
            REG_PAIRS: reg_rdata = pairs_cnt;
            REG_BEATS: reg_rdata = beats_cnt;
            default:   reg_rdata = '0;
        endcase
    end

endmodule

//--- design/tge_credit_tx.sv
`include "tge_defs.svh"

module tge_credit_tx (
    input  logic               clk,
    input  logic               rst,
    input  logic               beat_push,
    input  tge_pkg::tge_beat_t beat,
    output logic               beat_credit,
    input  logic               tge_credit,
    output tge_pkg::tge_beat_t tge_beat,
    output logic               tge_valid
);
    import tge_pkg::*;

    localparam int AW = $clog2(`TXQ_DEPTH);
    localparam int QW = $clog2(`TXQ_DEPTH + 1);
    localparam int EW = $clog2(`TGE_CREDIT_MAX + 1);

    tge_beat_t     queue [`TXQ_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [QW-1:0] q_count;
    logic [EW-1:0] ext_cnt;
    logic          send;

    // A beat leaves only when one is queued and the sink has granted room.
    assign send = (q_count != '0) && (ext_cnt != '0);

    // The slot freed by this send goes straight back to the unpacker.
    assign beat_credit = send;

    always_ff @(posedge clk) begin
        if (beat_push) begin
            queue[wr_ptr] <= beat;
        end
        if (send) begin
            tge_beat <= queue[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            tge_valid <= 1'b0;
        end else begin
            if (beat_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({beat_push, send})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            tge_valid <= send;
        end
    end

    // External credits saturate; a grant beyond the ceiling is lost.
    always_ff @(posedge clk) begin
        if (rst) begin
            ext_cnt <= '0;
        end else begin
            case ({tge_credit, send})
                2'b10: begin
                    if (ext_cnt != EW'(`TGE_CREDIT_MAX)) begin
                        ext_cnt <= ext_cnt + 1'b1;
                    end
                end
                2'b01:   ext_cnt <= ext_cnt - 1'b1;
                default: ext_cnt <= ext_cnt;
            endcase
        end
    end

endmodule

//--- design/dram_unpack.sv
`include "tge_defs.svh"

module dram_unpack (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  logic [2:0]          fifo_count,
    input  tge_pkg::dram_word_u fifo_dout,
    output logic                fifo_pop,
    output logic                beat_push,
    output tge_pkg::tge_beat_t  beat,
    input  logic                beat_credit,
    output logic                pair_done
);

    localparam int CW = $clog2(`TXQ_DEPTH + 1);
    localparam logic [3:0] LAST_BEAT = 4'(`BEATS_PER_PAIR - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SECOND,
        ST_EMIT
    } state_t;

    state_t                              state;
    logic [3:0]                          beat_idx;
    logic [CW-1:0]                       credit_cnt;
    logic [`BEATS_PER_PAIR-1:0][`TGE_W-1:0] lanes;
    logic                                start;
    logic                                emit;

    // A pair is only started when both of its words are already queued.
    assign start = (state == ST_IDLE) && enable && (fifo_count >= 3'd2);
    assign emit  = (state == ST_EMIT) && (credit_cnt != '0);

    // First pop in the idle cycle, second pop straight after it.
    assign fifo_pop = start || (state == ST_SECOND);

    // Lane storage; lane 4 is stitched together from both words of the pair.
    always_ff @(posedge clk) begin
        if (start) begin
            lanes[3:0]      <= fifo_dout.first.lanes;
            lanes[4][31:0]  <= fifo_dout.first.lane4_lo;
        end
        if (state == ST_SECOND) begin
            lanes[4][63:32] <= fifo_dout.second.lane4_hi;
            lanes[8:5]      <= fifo_dout.second.lanes;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            beat_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_SECOND;
                    end
                end
                ST_SECOND: begin
                    state    <= ST_EMIT;
                    beat_idx <= '0;
                end
                ST_EMIT: begin
                    if (emit) begin
                        if (beat_idx == LAST_BEAT) begin
                            // The next pair waits for this one to drain completely.
                            state <= ST_IDLE;
                        end
                        beat_idx <= beat_idx + 4'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Internal credits track free room in the transmit queue.
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CW'(`TXQ_DEPTH);
        end else begin
            case ({emit, beat_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_push <= 1'b0;
            pair_done <= 1'b0;
        end else begin
            beat_push <= emit;
            pair_done <= emit && (beat_idx == LAST_BEAT);
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            beat.data <= lanes[beat_idx];
            beat.lane <= beat_idx;
        end
    end

endmodule

//--- design/dram_rd_fifo.sv
`include "tge_defs.svh"

module dram_rd_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  tge_pkg::dram_word_u din,
    input  logic                pop,
    output tge_pkg::dram_word_u dout,
    output logic [2:0]          count,
    output logic                credit
);
    import tge_pkg::*;

    localparam int AW = $clog2(`DRAM_FIFO_DEPTH);

    dram_word_u    mem [`DRAM_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    // A push into a full FIFO is dropped here; upstream credits should prevent it.
    assign do_push = push && (count != 3'(`DRAM_FIFO_DEPTH));
    assign do_pop  = pop && (count != 3'd0);

    // Head of the queue is always visible, so the consumer can sample it
    // in the same cycle it pops.
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
            // Every word that leaves frees one slot for the DRAM source.
            credit <= do_pop;
        end
    end

endmodule

//--- design/tge_pkg.sv
`include "tge_defs.svh"

package tge_pkg;

    // First word of a pair: lanes 0..3 at the bottom, then the low half of lane 4.
    typedef struct packed {
        logic [31:0]                lane4_lo;
        logic [3:0][`TGE_W-1:0]     lanes;
    } dram_first_t;

    // Second word of a pair: the high half of lane 4 at the bottom, then lanes 5..8.
    typedef struct packed {
        logic [3:0][`TGE_W-1:0]     lanes;
        logic [31:0]                lane4_hi;
    } dram_second_t;

    // The same 288 bits seen raw, or through either half-of-pair view.
    typedef union packed {
        logic [`DRAM_W-1:0]         raw;
        dram_first_t                first;
        dram_second_t               second;
    } dram_word_u;

    // One outgoing beat, tagged with its position inside the pair.
    typedef struct packed {
        logic [`TGE_W-1:0]          data;
        logic [3:0]                 lane;
    } tge_beat_t;

    // Register map of the control block.
    typedef enum logic [31:0] {
        REG_CTRL  = 32'h0000_0000,
        REG_PAIRS = 32'h0000_0004,
        REG_BEATS = 32'h0000_0008
    } reg_addr_e;

endpackage

//--- design/tge_defs.svh
`ifndef TGE_DEFS_SVH
`define TGE_DEFS_SVH

// Width of one word as it comes back from the DRAM read port.
`define DRAM_W 288

// Width of one beat on the 10G Ethernet transmit path.
`define TGE_W 64

// Two DRAM words carry exactly this many TGE beats.
`define BEATS_PER_PAIR 9

// Input FIFO depth.
// The DRAM source starts out with this many credits after reset.
`define DRAM_FIFO_DEPTH 4

// Transmit queue depth.
// The unpacker starts out with this many internal credits after reset.
`define TXQ_DEPTH 4

// Ceiling of the external credit counter in the transmit queue.
`define TGE_CREDIT_MAX 15

`endif
